/* Bender.yml */
package:
  name: read_counter

sources:
  - source/counter_pkg.sv
  - source/switch_pkg.sv
  - source/phase_sequencer.sv
  - source/updown_counter.sv
  - source/fine_decoder.sv
  - source/coarse_decoder.sv
  - source/read_counter.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/read_counter_tb.sv

/* sim/read_counter_tb.sv */
`timescale 1ns/1ps

module read_counter_tb;
    import counter_pkg::*;
    import switch_pkg::*;

    localparam int UP_OPS         = 20;
    localparam int DOWN_OPS       = 12;
    localparam int MISC_OPS       = 7;
    localparam int RANDOM_OPS     = 320;
    localparam int NUM_OPS        = UP_OPS + 1 + DOWN_OPS + MISC_OPS + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = 8 * NUM_OPS + 50;

    // One phase cycle of stimulus
    // zero_mode 1 puts cduz on the step cycle, 2 puts it after the update
    typedef struct packed {
        logic       pi;
        logic       up;
        logic       dn;
        logic       extra;
        logic       up2;
        logic       dn2;
        logic [1:0] zero_mode;
    } op_t;

    typedef struct packed {
        logic [15:0] count;
        logic        del0;
        logic        del2;
    } expect_t;

    typedef struct packed {
        logic [31:0] due;
        expect_t     exp;
    } check_t;

    logic           clk;
    logic           rst_n;
    logic           faz2;
    logic           faz3;
    logic           pi;
    logic           up_lvl;
    logic           dn_lvl;
    logic           cduz;
    count_word_u    count;
    fine_switch_t   fine_sw;
    coarse_switch_t coarse_sw;
    logic           del0;
    logic           del2;

    logic [31:0]    cycle = 0;
    int             seed;
    logic [15:0]    model_count;
    check_t         checks[$];

    tb_clock_gen #(
        .HALF_PERIOD_NS (4),
        .RESET_CYCLES   (3)
    ) tb_clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    read_counter read_counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .faz2      (faz2),
        .faz3      (faz3),
        .pi        (pi),
        .up_lvl    (up_lvl),
        .dn_lvl    (dn_lvl),
        .cduz      (cduz),
        .count     (count),
        .fine_sw   (fine_sw),
        .coarse_sw (coarse_sw),
        .del0      (del0),
        .del2      (del2)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value check failed");
        end
    endtask

    // Expected count and strobes after one phase cycle
    function automatic expect_t predict(input logic [15:0] old, input op_t op);
        logic    take;
        logic    dir_up;
        expect_t e;
        take   = 1'b0;
        dir_up = 1'b0;
        // A second pulse only lands if the first one was not captured
        if (op.pi && (op.up ^ op.dn)) begin
            take   = 1'b1;
            dir_up = op.up;
        end else if (op.extra && (op.up2 ^ op.dn2)) begin
            take   = 1'b1;
            dir_up = op.up2;
        end
        e.count = old;
        e.del0  = 1'b0;
        e.del2  = 1'b0;
        if (take) begin
            e.count = dir_up ? old + 16'd1 : old - 16'd1;
            e.del0  = dir_up ? old[0] : !old[0];
            e.del2  = dir_up ? (old[2:0] == 3'b111) : (old[2:0] == 3'b000);
        end
        if (op.zero_mode == 2'd1) begin
            e = '0;
        end
        return e;
    endfunction

    function automatic fine_switch_t expected_fine(input logic [15:0] value);
        fine_switch_t f;
        f.stage     = value[6:0];
        f.fine_line = 8'b1 << value[12:10];
        return f;
    endfunction

    // Sector c and the one above it
    function automatic coarse_switch_t expected_coarse(input logic [15:0] value);
        logic [7:0]     s;
        coarse_switch_t c;
        s        = 8'b1 << value[15:13];
        c.sector = s | {s[6:0], s[7]};
        return c;
    endfunction

    function automatic op_t make_op(input logic p, input logic u, input logic d,
                                    input logic x, input logic u2, input logic d2,
                                    input logic [1:0] zm);
        op_t op;
        op.pi        = p;
        op.up        = u;
        op.dn        = d;
        op.extra     = x;
        op.up2       = u2;
        op.dn2       = d2;
        op.zero_mode = zm;
        return op;
    endfunction

    task automatic run_op(input op_t op);
        check_t item;
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #1;
            if (c == 0) begin
                item.due = cycle + 5;
                item.exp = predict(model_count, op);
                checks.push_back(item);
            end
            faz2   = (c == 0) || (c == 1 && op.extra);
            pi     = (c == 0) ? op.pi : (c == 1 && op.extra);
            up_lvl = (c == 0) ? op.up : (c == 1 && op.extra && op.up2);
            dn_lvl = (c == 0) ? op.dn : (c == 1 && op.extra && op.dn2);
            faz3   = (c == 3);
            cduz   = (op.zero_mode == 2'd1 && c == 4) || (op.zero_mode == 2'd2 && c == 6);
        end
        model_count = (op.zero_mode == 2'd2) ? 16'd0 : item.exp.count;
    endtask

    // Count and strobes land two cycles after faz3, switches one later
    always @(negedge clk) begin
        if (checks.size() > 0) begin
            if (cycle == checks[0].due) begin
                check_value("count", count.raw, checks[0].exp.count);
                check_value("del0", del0, checks[0].exp.del0);
                check_value("del2", del2, checks[0].exp.del2);
            end else if (cycle == checks[0].due + 1) begin
                check_value("fine_sw", fine_sw, expected_fine(checks[0].exp.count));
                check_value("coarse_sw", coarse_sw, expected_coarse(checks[0].exp.count));
                void'(checks.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "simulation timeout");
        end else begin
            cycle <= cycle + 1;
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [1:0]  mode;
        faz2        = 1'b0;
        faz3        = 1'b0;
        pi          = 1'b0;
        up_lvl      = 1'b0;
        dn_lvl      = 1'b0;
        cduz        = 1'b0;
        seed        = 93571;
        model_count = 16'd0;

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("count", count.raw, 16'd0);
        check_value("del0", del0, 1'b0);
        check_value("del2", del2, 1'b0);
        check_value("fine_sw.stage", fine_sw.stage, 7'd0);
        check_value("fine_sw.fine_line", fine_sw.fine_line, 8'b0000_0001);
        check_value("coarse_sw.sector", coarse_sw.sector, 8'b0000_0011);

        repeat (UP_OPS) run_op(make_op(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0));

        // Zero, then count down through the wrap
        run_op(make_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd2));
        repeat (DOWN_OPS) run_op(make_op(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0));

        // Pulses that must be dropped, pending request, zeroing
        run_op(make_op(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
        run_op(make_op(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0));
        run_op(make_op(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0));
        run_op(make_op(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0));
        run_op(make_op(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0));
        run_op(make_op(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1));
        run_op(make_op(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2));

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = $random(seed);
            mode = 2'd0;
            if (r[12:8] == 5'd0) begin
                mode = 2'd1;
            end else if (r[12:8] == 5'd1) begin
                mode = 2'd2;
            end
            run_op(make_op(r[0] | r[1], r[2], r[3], r[4] & r[5], r[6], r[7], mode));
        end

        wait (checks.size() == 0);
        repeat (2) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* source/coarse_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module coarse_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  counter_pkg::count_word_u   count,
    output switch_pkg::coarse_switch_t coarse_sw
);
    import counter_pkg::*;
    import switch_pkg::*;

    logic [COARSE_WIDTH-1:0] coarse;
    coarse_switch_t          sw_next;

    assign coarse = count.fields.coarse;

    // Line k is on for sector k and for the sector below it,
    // so the resolver always has an overlap at a handover
    always_comb begin
        for (int k = 0; k < SECTOR_LINES; k++) begin
            sw_next.sector[k] = (coarse == COARSE_WIDTH'(k)) ||
                                (coarse == COARSE_WIDTH'(k - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Sector 0 on a zero count
            coarse_sw.sector <= SECTOR_LINES'(3);
        end else begin
            coarse_sw <= sw_next;
        end
    end

endmodule

`default_nettype wire

/* source/counter_pkg.sv */
package counter_pkg;

    // Converter word format
    localparam int COUNT_WIDTH = 16;
    localparam int COARSE_WIDTH = 3;
    localparam int FINE_WIDTH = 3;
    localparam int LOW_WIDTH = COUNT_WIDTH - COARSE_WIDTH - FINE_WIDTH;

    // Field view of the count, MSB first
    typedef struct packed {
        logic [COARSE_WIDTH-1:0] coarse;
        logic [FINE_WIDTH-1:0]   fine;
        logic [LOW_WIDTH-1:0]    low;
    } count_fields_t;

    // Raw view for stepping, field view for the switch decoders
    typedef union packed {
        logic [COUNT_WIDTH-1:0] raw;
        count_fields_t          fields;
    } count_word_u;

    // One count request toward the counter
    typedef struct packed {
        logic step;
        logic up;
    } count_cmd_t;

endpackage

/* source/fine_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module fine_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  counter_pkg::count_word_u count,
    output switch_pkg::fine_switch_t fine_sw
);
    import counter_pkg::*;
    import switch_pkg::*;

    fine_switch_t sw_next;

    always_comb begin
        // Lowest stages follow the count bits directly
        sw_next.stage = count.fields.low[STAGE_LINES-1:0];

        // Vernier line select, one-hot of the fine field
        for (int k = 0; k < SECTOR_LINES; k++) begin
            sw_next.fine_line[k] = (count.fields.fine == FINE_WIDTH'(k));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fine_sw.stage     <= '0;
            fine_sw.fine_line <= SECTOR_LINES'(1);
        end else begin
            fine_sw <= sw_next;
        end
    end

endmodule

`default_nettype wire

/* source/phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    faz2,
    input  logic                    faz3,
    input  logic                    pi,
    input  logic                    up_lvl,
    input  logic                    dn_lvl,
    output counter_pkg::count_cmd_t cmd
);
    import counter_pkg::*;

    logic       pending;
    logic       pend_up;
    logic       capture;
    logic       issue;
    count_cmd_t cmd_next;

    // Exactly one direction level must be set for a valid pulse
    assign capture = faz2 && pi && (up_lvl ^ dn_lvl) && !pending;

    // Only a request already pending before this cycle can go out
    assign issue = faz3 && pending;

    always_comb begin
        cmd_next.step = issue;
        cmd_next.up   = issue && pend_up;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            cmd     <= '0;
        end else begin
            cmd <= cmd_next;
            if (capture) begin
                pending <= 1'b1;
            end else if (issue) begin
                pending <= 1'b0;
            end
        end
    end

    // Direction latched with the pulse
    always_ff @(posedge clk) begin
        if (capture) begin
            pend_up <= up_lvl;
        end
    end

endmodule

`default_nettype wire

/* source/read_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       faz2,
    input  logic                       faz3,
    input  logic                       pi,
    input  logic                       up_lvl,
    input  logic                       dn_lvl,
    input  logic                       cduz,
    output counter_pkg::count_word_u   count,
    output switch_pkg::fine_switch_t   fine_sw,
    output switch_pkg::coarse_switch_t coarse_sw,
    output logic                       del0,
    output logic                       del2
);
    import counter_pkg::*;

    count_cmd_t cmd;

    phase_sequencer phase_sequencer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .faz2   (faz2),
        .faz3   (faz3),
        .pi     (pi),
        .up_lvl (up_lvl),
        .dn_lvl (dn_lvl),
        .cmd    (cmd)
    );

    updown_counter updown_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .cduz  (cduz),
        .count (count),
        .del0  (del0),
        .del2  (del2)
    );

    fine_decoder fine_decoder_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .count   (count),
        .fine_sw (fine_sw)
    );

    coarse_decoder coarse_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .count     (count),
        .coarse_sw (coarse_sw)
    );

endmodule

`default_nettype wire

/* source/switch_pkg.sv */
package switch_pkg;

    // Low stages driven straight from count bits
    localparam int STAGE_LINES = 7;

    // Lines per decoder ladder
    localparam int SECTOR_LINES = 8;

    // Fine ladder: direct stages plus the vernier line select
    typedef struct packed {
        logic [STAGE_LINES-1:0]  stage;
        logic [SECTOR_LINES-1:0] fine_line;
    } fine_switch_t;

    // Coarse ladder, two neighbouring sectors on at a time
    typedef struct packed {
        logic [SECTOR_LINES-1:0] sector;
    } coarse_switch_t;

endpackage

/* source/updown_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module updown_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  counter_pkg::count_cmd_t  cmd,
    input  logic                     cduz,
    output counter_pkg::count_word_u count,
    output logic                     del0,
    output logic                     del2
);
    import counter_pkg::*;

    logic [COUNT_WIDTH-1:0] toggle;
    logic [COUNT_WIDTH-1:0] next_raw;

    // Ripple toggle chain
    // Up passes on through ones, down passes on through zeros
    always_comb begin
        toggle[0] = cmd.step;
        for (int i = 1; i < COUNT_WIDTH; i++) begin
            toggle[i] = toggle[i-1] & (count.raw[i-1] ~^ cmd.up);
        end
    end

    assign next_raw = count.raw ^ toggle;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count.raw <= '0;
            del0      <= 1'b0;
            del2      <= 1'b0;
        end else if (cduz) begin
            // Zeroing overrides any step
            count.raw <= '0;
            del0      <= 1'b0;
            del2      <= 1'b0;
        end else begin
            count.raw <= next_raw;
            // Carry or borrow out of bit 0 reaches bit 1
            del0      <= toggle[1];
            // Out of bit 2 reaches bit 3
            del2      <= toggle[3];
        end
    end

endmodule

`default_nettype wire

/* sources.f */
source/counter_pkg.sv
source/switch_pkg.sv
source/phase_sequencer.sv
source/updown_counter.sv
source/fine_decoder.sv
source/coarse_decoder.sv
source/read_counter.sv
sim/tb_clock_gen.sv
sim/read_counter_tb.sv
